// ==== logic/chip_tag_pkg.sv ====
package chip_tag_pkg;

  ////////////////////////////////////////////////////////////////////
  // Tag packet framing

  // Field widths
  localparam int tag_client_bits  = 2;
  localparam int tag_payload_bits = 8;

  // Start bit, then client number, then payload, MSB first
  localparam int tag_packet_bits = 1 + tag_client_bits + tag_payload_bits;

  typedef logic [tag_client_bits-1:0]  tag_client_t;
  typedef logic [tag_payload_bits-1:0] tag_payload_t;

  // Bit position inside the current field
  typedef logic [$clog2(tag_payload_bits)-1:0] tag_bit_cnt_t;

  localparam tag_bit_cnt_t tag_client_last  = tag_bit_cnt_t'(tag_client_bits - 1);
  localparam tag_bit_cnt_t tag_payload_last = tag_bit_cnt_t'(tag_payload_bits - 1);

  ////////////////////////////////////////////////////////////////////
  // Client numbering

  // Client 3 is reserved
  localparam tag_client_t client_div_a  = 2'd0;
  localparam tag_client_t client_div_b  = 2'd1;
  localparam tag_client_t client_enable = 2'd2;

  ////////////////////////////////////////////////////////////////////
  // Tag master FSM

  typedef enum logic [1:0]
  {
    tag_idle_s,
    tag_header_s,
    tag_payload_s
  } tag_state_e;

endpackage

// ==== logic/chip_clk_pkg.sv ====
package chip_clk_pkg;

  ////////////////////////////////////////////////////////////////////
  // Divider and rate counter widths

  // Same width as a tag payload
  typedef logic [7:0] div_ratio_t;

  // Wraps on overflow
  typedef logic [15:0] tick_count_t;

  ////////////////////////////////////////////////////////////////////
  // Output select codes

  typedef logic [1:0] out_sel_t;

  localparam out_sel_t out_sel_a        = 2'd0;
  localparam out_sel_t out_sel_b        = 2'd1;

  // Both upper codes route constant zero
  localparam out_sel_t out_sel_zero     = 2'd2;
  localparam out_sel_t out_sel_zero_alt = 2'd3;

  // Bit positions in the enable client register
  localparam int enable_bit_a = 0;
  localparam int enable_bit_b = 1;

endpackage

// ==== logic/tag_master.sv ====
module tag_master
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     tag_en_i,
  input  logic                     tag_data_i,
  output chip_clk_pkg::div_ratio_t ratio_a_o,
  output chip_clk_pkg::div_ratio_t ratio_b_o,
  output logic [1:0]               enable_o,
  output logic                     load_a_o,
  output logic                     load_b_o
);

  chip_tag_pkg::tag_state_e   state_r;
  chip_tag_pkg::tag_bit_cnt_t bit_cnt_r;

  // Client and payload bits before the one on the line, start bit not kept
  logic [chip_tag_pkg::tag_packet_bits-3:0] shift_r;
  logic [chip_tag_pkg::tag_packet_bits-2:0] packet_word;

  chip_tag_pkg::tag_client_t  pkt_client;
  chip_tag_pkg::tag_payload_t pkt_payload;
  logic                       pkt_done;

  chip_clk_pkg::div_ratio_t ratio_a_r;
  chip_clk_pkg::div_ratio_t ratio_b_r;
  logic [1:0]               enable_r;
  logic                     load_a_r;
  logic                     load_b_r;

  ////////////////////////////////////////////////////////////////////
  // Deserializer

  // Word including the bit on the line this cycle
  assign packet_word = {shift_r, tag_data_i};
  assign pkt_client  = packet_word[chip_tag_pkg::tag_packet_bits-2 -:
                                   chip_tag_pkg::tag_client_bits];
  assign pkt_payload = packet_word[chip_tag_pkg::tag_payload_bits-1:0];

  assign pkt_done = (state_r == chip_tag_pkg::tag_payload_s) && tag_en_i
                    && (bit_cnt_r == chip_tag_pkg::tag_payload_last);

  always_ff @(posedge clk_i)
  begin
    if (tag_en_i && (state_r != chip_tag_pkg::tag_idle_s))
      shift_r <= packet_word[chip_tag_pkg::tag_packet_bits-3:0];
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r   <= chip_tag_pkg::tag_idle_s;
      bit_cnt_r <= '0;
    end
    else if (!tag_en_i)
    begin
      // Dropping enable abandons any packet in flight
      state_r   <= chip_tag_pkg::tag_idle_s;
      bit_cnt_r <= '0;
    end
    else
    begin
      case (state_r)
        chip_tag_pkg::tag_idle_s:
        begin
          bit_cnt_r <= '0;
          if (tag_data_i)
            state_r <= chip_tag_pkg::tag_header_s;
        end
        chip_tag_pkg::tag_header_s:
        begin
          if (bit_cnt_r == chip_tag_pkg::tag_client_last)
          begin
            state_r   <= chip_tag_pkg::tag_payload_s;
            bit_cnt_r <= '0;
          end
          else
            bit_cnt_r <= bit_cnt_r + 1'b1;
        end
        chip_tag_pkg::tag_payload_s:
        begin
          if (pkt_done)
          begin
            state_r   <= chip_tag_pkg::tag_idle_s;
            bit_cnt_r <= '0;
          end
          else
            bit_cnt_r <= bit_cnt_r + 1'b1;
        end
        default:
          state_r <= chip_tag_pkg::tag_idle_s;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Client registers

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      ratio_a_r <= '0;
      ratio_b_r <= '0;
      enable_r  <= '0;
      load_a_r  <= 1'b0;
      load_b_r  <= 1'b0;
    end
    else
    begin
      load_a_r <= 1'b0;
      load_b_r <= 1'b0;
      if (pkt_done)
      begin
        case (pkt_client)
          chip_tag_pkg::client_div_a:
          begin
            ratio_a_r <= pkt_payload;
            load_a_r  <= 1'b1;
          end
          chip_tag_pkg::client_div_b:
          begin
            ratio_b_r <= pkt_payload;
            load_b_r  <= 1'b1;
          end
          chip_tag_pkg::client_enable:
          begin
            enable_r <= pkt_payload[1:0];
            load_a_r <= 1'b1;
            load_b_r <= 1'b1;
          end
          default:
          begin
            // Reserved client, packet dropped
            load_a_r <= 1'b0;
            load_b_r <= 1'b0;
          end
        endcase
      end
    end
  end

  assign ratio_a_o = ratio_a_r;
  assign ratio_b_o = ratio_b_r;
  assign enable_o  = enable_r;
  assign load_a_o  = load_a_r;
  assign load_b_o  = load_b_r;

endmodule

// ==== logic/tick_divider.sv ====
module tick_divider
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  chip_clk_pkg::div_ratio_t ratio_i,
  input  logic                     enable_i,
  input  logic                     load_i,
  output logic                     tick_o
);

  chip_clk_pkg::div_ratio_t cnt_r;
  logic                     tick_r;

  // Tick on zero, then count down from the ratio
  // Period is ratio+1 cycles
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      cnt_r  <= '0;
      tick_r <= 1'b0;
    end
    else if (load_i || !enable_i)
    begin
      // Restart so a new period starts cleanly
      cnt_r  <= '0;
      tick_r <= 1'b0;
    end
    else if (cnt_r == '0)
    begin
      cnt_r  <= ratio_i;
      tick_r <= 1'b1;
    end
    else
    begin
      cnt_r  <= cnt_r - 1'b1;
      tick_r <= 1'b0;
    end
  end

  assign tick_o = tick_r;

endmodule

// ==== logic/tick_out_select.sv ====
module tick_out_select
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      tick_a_i,
  input  logic                      tick_b_i,
  input  chip_clk_pkg::out_sel_t    sel_i,
  input  logic                      out_disable_i,
  output logic                      tick_o,
  output chip_clk_pkg::tick_count_t tick_count_o
);

  logic                      sel_tick;
  logic                      gated_tick;
  logic                      tick_r;
  chip_clk_pkg::out_sel_t    sel_q_r;
  logic                      sel_changed;
  chip_clk_pkg::tick_count_t count_r;

  ////////////////////////////////////////////////////////////////////
  // Output mux and gate

  always_comb
  begin
    case (sel_i)
      chip_clk_pkg::out_sel_a:        sel_tick = tick_a_i;
      chip_clk_pkg::out_sel_b:        sel_tick = tick_b_i;
      chip_clk_pkg::out_sel_zero,
      chip_clk_pkg::out_sel_zero_alt: sel_tick = 1'b0;
      default:                        sel_tick = 1'b0;
    endcase
  end

  assign gated_tick = sel_tick & ~out_disable_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      tick_r <= 1'b0;
    else
      tick_r <= gated_tick;
  end

  ////////////////////////////////////////////////////////////////////
  // Rate counter

  // Previous select, so a switch clears the count
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      sel_q_r <= chip_clk_pkg::out_sel_a;
    else
      sel_q_r <= sel_i;
  end

  assign sel_changed = (sel_i != sel_q_r);

  always_ff @(posedge clk_i)
  begin
    if (rst_i || out_disable_i || sel_changed)
      count_r <= '0;
    else if (tick_r)
      count_r <= count_r + 1'b1;
  end

  assign tick_o       = tick_r;
  assign tick_count_o = count_r;

endmodule

// ==== logic/chip_top.sv ====
module chip_top
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      tag_en_i,
  input  logic                      tag_data_i,
  input  chip_clk_pkg::out_sel_t    sel_i,
  input  logic                      out_disable_i,
  output logic                      tick_o,
  output chip_clk_pkg::tick_count_t tick_count_o
);

  ////////////////////////////////////////////////////////////////////
  // Tag master

  chip_clk_pkg::div_ratio_t ratio_a_lo;
  chip_clk_pkg::div_ratio_t ratio_b_lo;
  logic [1:0]               enable_lo;
  logic                     load_a_lo;
  logic                     load_b_lo;

  tag_master u_tag
    (.clk_i      ( clk_i      )
    ,.rst_i      ( rst_i      )
    ,.tag_en_i   ( tag_en_i   )
    ,.tag_data_i ( tag_data_i )
    ,.ratio_a_o  ( ratio_a_lo )
    ,.ratio_b_o  ( ratio_b_lo )
    ,.enable_o   ( enable_lo  )
    ,.load_a_o   ( load_a_lo  )
    ,.load_b_o   ( load_b_lo  )
    );

  ////////////////////////////////////////////////////////////////////
  // Tick dividers

  logic tick_a_lo;
  logic tick_b_lo;

  tick_divider u_div_a
    (.clk_i    ( clk_i                                )
    ,.rst_i    ( rst_i                                )
    ,.ratio_i  ( ratio_a_lo                           )
    ,.enable_i ( enable_lo[chip_clk_pkg::enable_bit_a] )
    ,.load_i   ( load_a_lo                            )
    ,.tick_o   ( tick_a_lo                            )
    );

  tick_divider u_div_b
    (.clk_i    ( clk_i                                )
    ,.rst_i    ( rst_i                                )
    ,.ratio_i  ( ratio_b_lo                           )
    ,.enable_i ( enable_lo[chip_clk_pkg::enable_bit_b] )
    ,.load_i   ( load_b_lo                            )
    ,.tick_o   ( tick_b_lo                            )
    );

  ////////////////////////////////////////////////////////////////////
  // Output select, off chip

  tick_out_select u_out
    (.clk_i         ( clk_i         )
    ,.rst_i         ( rst_i         )
    ,.tick_a_i      ( tick_a_lo     )
    ,.tick_b_i      ( tick_b_lo     )
    ,.sel_i         ( sel_i         )
    ,.out_disable_i ( out_disable_i )
    ,.tick_o        ( tick_o        )
    ,.tick_count_o  ( tick_count_o  )
    );

endmodule

// ==== verif/chip_top_tb.sv ====
module chip_top_tb;

  localparam int num_rows      = 10;
  localparam int settle_cycles = 6;
  localparam int idle_cycles   = 20;
  // Packet bits plus the idle cycle that follows
  localparam int packet_cycles = chip_tag_pkg::tag_packet_bits + 1;

  logic                      clk_i = 1'b0;
  logic                      rst_i;
  logic                      tag_en_i;
  logic                      tag_data_i;
  chip_clk_pkg::out_sel_t    sel_i;
  logic                      out_disable_i;
  logic                      tick_o;
  chip_clk_pkg::tick_count_t tick_count_o;

  ////////////////////////////////////////////////////////////////////
  // Test table, one array per column

  int ratio_a_tab [num_rows] = '{0, 3, 0, 2, 1, 3, 3, 3, 3, 4};
  int ratio_b_tab [num_rows] = '{5, 5, 2, 4, 0, 3, 3, 1, 1, 1};
  int enable_tab  [num_rows] = '{1, 3, 3, 3, 3, 3, 3, 3, 2, 1};
  int sel_tab     [num_rows] = '{0, 0, 0, 1, 1, 2, 3, 0, 0, 0};
  int disable_tab [num_rows] = '{0, 0, 0, 0, 0, 0, 0, 1, 0, 0};
  int k_tab       [num_rows] = '{6, 5, 3, 5, 3, 4, 4, 4, 4, 4};
  int abort_tab   [num_rows] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1};

  int seed          = 18;
  int error_count   = 0;
  int test_count    = 0;
  int fail_count    = 0;
  int cycle_count   = 0;
  int timeout_limit = 0;

  always #10 clk_i = ~clk_i;

  chip_top u_dut
    (.clk_i         ( clk_i         )
    ,.rst_i         ( rst_i         )
    ,.tag_en_i      ( tag_en_i      )
    ,.tag_data_i    ( tag_data_i    )
    ,.sel_i         ( sel_i         )
    ,.out_disable_i ( out_disable_i )
    ,.tick_o        ( tick_o        )
    ,.tick_count_o  ( tick_count_o  )
    );

  always @(posedge clk_i)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit)
    begin
      $display("Timeout: tests did not finish within %0d cycles", timeout_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Reference model and helpers

  // Only an enabled divider on select 0 or 1 reaches the counter
  function automatic int expected_growth(input int enable_mask, input int sel,
                                         input int dis, input int k);
    logic routed;
    routed = ((sel == 0) && enable_mask[0]) || ((sel == 1) && enable_mask[1]);
    if (routed && (dis == 0))
      return k;
    else
      return 0;
  endfunction

  function automatic int window_cycles(input int row);
    if (sel_tab[row] == 1)
      return k_tab[row] * (ratio_b_tab[row] + 1);
    else
      return k_tab[row] * (ratio_a_tab[row] + 1);
  endfunction

  function automatic int total_cycles();
    int sum;
    sum = 2 + 4 * (idle_cycles + 1);
    for (int row = 0; row < num_rows; row++)
      sum += window_cycles(row) + 5 * packet_cycles + settle_cycles + 2;
    return sum;
  endfunction

  task automatic check_value(input string what, input int actual, input int expected);
    if (actual !== expected)
    begin
      error_count++;
      $display("** Error at time %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before)
      $display("Test %0d (%s): ok", test_count, name);
    else
    begin
      fail_count++;
      $display("Test %0d (%s): failed", test_count, name);
    end
  endtask

  // Start bit, client, payload, MSB first; abort_at < 0 sends it whole
  task automatic send_packet(input chip_tag_pkg::tag_client_t client,
                             input chip_tag_pkg::tag_payload_t payload,
                             input int abort_at);
    logic [chip_tag_pkg::tag_packet_bits-1:0] bits;
    int n;
    bits = {1'b1, client, payload};
    n = 0;
    while ((n < chip_tag_pkg::tag_packet_bits) && (n != abort_at))
    begin
      @(posedge clk_i);
      tag_en_i   <= 1'b1;
      tag_data_i <= bits[chip_tag_pkg::tag_packet_bits - 1 - n];
      n++;
    end
    @(posedge clk_i);
    tag_en_i   <= 1'b0;
    tag_data_i <= 1'b0;
  endtask

  task automatic check_idle(input int sel);
    int errors_before;
    errors_before = error_count;
    @(posedge clk_i);
    sel_i <= chip_clk_pkg::out_sel_t'(sel);
    repeat (idle_cycles) @(posedge clk_i);
    @(negedge clk_i);
    check_value($sformatf("idle count on sel %0d", sel), int'(tick_count_o), 0);
    check_value($sformatf("idle tick_o on sel %0d", sel), int'(tick_o), 0);
    finish_test($sformatf("unconfigured, sel %0d", sel), errors_before);
  endtask

  task automatic run_row(input int row);
    int                        errors_before;
    int                        growth;
    int                        pulses;
    int                        expected;
    chip_tag_pkg::tag_payload_t ratio_a;
    chip_clk_pkg::tick_count_t count_before;
    chip_clk_pkg::tick_count_t count_after;
    errors_before = error_count;
    expected = expected_growth(enable_tab[row], sel_tab[row], disable_tab[row], k_tab[row]);
    ratio_a = chip_tag_pkg::tag_payload_t'(ratio_a_tab[row]);
    send_packet(chip_tag_pkg::client_div_a, ratio_a, -1);
    send_packet(chip_tag_pkg::client_div_b,
                chip_tag_pkg::tag_payload_t'(ratio_b_tab[row]), -1);
    send_packet(chip_tag_pkg::client_enable,
                chip_tag_pkg::tag_payload_t'(enable_tab[row]), -1);
    if (abort_tab[row] != 0)
    begin
      // Dropped after client field and three payload bits
      send_packet(chip_tag_pkg::client_div_a, ~ratio_a, 6);
      send_packet(chip_tag_pkg::tag_client_t'(3), 8'h07, -1);
    end
    @(posedge clk_i);
    sel_i         <= chip_clk_pkg::out_sel_t'(sel_tab[row]);
    out_disable_i <= (disable_tab[row] != 0);
    repeat (settle_cycles) @(posedge clk_i);
    @(negedge clk_i);
    count_before = tick_count_o;
    pulses = 0;
    // Each output pulse seen here is counted before the window closes
    repeat (window_cycles(row))
    begin
      if (tick_o === 1'b1)
        pulses++;
      @(negedge clk_i);
    end
    count_after = tick_count_o;
    growth = int'(count_after - count_before);
    check_value($sformatf("row %0d count growth", row), growth, expected);
    check_value($sformatf("row %0d tick_o pulses", row), pulses, expected);
    finish_test($sformatf("row %0d, sel %0d, %0d cycles, growth %0d",
                          row, sel_tab[row], window_cycles(row), growth), errors_before);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Main sequence

  initial
  begin
    rst_i         <= 1'b1;
    tag_en_i      <= 1'b0;
    tag_data_i    <= 1'b0;
    sel_i         <= chip_clk_pkg::out_sel_a;
    out_disable_i <= 1'b0;
    ratio_a_tab[2] = $random(seed) & 255;
    ratio_b_tab[4] = $random(seed) & 255;
    timeout_limit  = 2 * total_cycles();
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
    for (int s = 0; s < 4; s++)
      check_idle(s);
    for (int row = 0; row < num_rows; row++)
      run_row(row);
    $display("Tests run: %0d, passed: %0d, failed: %0d",
             test_count, test_count - fail_count, fail_count);
    if (error_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== all.f ====
logic/chip_tag_pkg.sv
logic/chip_clk_pkg.sv
logic/tag_master.sv
logic/tick_divider.sv
logic/tick_out_select.sv
logic/chip_top.sv
verif/chip_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the chip_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module chip_top_tb -o chip_top_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/chip_top_tb_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Result: PASSED" <<< "$sim_out"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
